//--- wb_xbar.f
design/wb_xbar_pkg.sv
design/xbar_fifo.sv
design/xbar_master_port.sv
design/xbar_slave_port.sv
design/wb_xbar_top.sv
verification/tb_xbar_models.sv
verification/tb_wb_xbar.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the crossbar testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wb_xbar -f wb_xbar.f -o sim_wb_xbar
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/sim_wb_xbar > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- verification/tb_wb_xbar.sv
/*
  Testbench for the two by two Wishbone crossbar
  Drives random pipelined traffic on both masters, models each
  master's memory view, and checks responses, slave-side requests,
  age order on a shared slave and back-pressure.
*/
`default_nettype none

module tb_wb_xbar
  import wb_xbar_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TOTAL_REQ = 2 * 60 + 2 * 40 + 20 + 30;
  localparam int WATCHDOG_CYCLES = TOTAL_REQ * 40 + 2000;
  localparam logic [31:0] NO_SLAVE = 32'h3000_0000;

  typedef struct packed {
    logic        err;
    logic        rd;
    logic [31:0] data;
  } exp_rsp_t;

  logic      clk_i;
  logic      rst_i = 1'b1;
  wb_m2s_t   m_req [2] = '{default: '0};
  wb_m_rsp_t m_rsp [2];
  wb_m2s_t   s_req [2];
  wb_s2m_t   s_rsp [2];
  logic      hold [2] = '{1'b0, 1'b0};
  logic      heavy [2] = '{1'b0, 1'b0};

  logic [31:0] lcg_state = 32'd3041;
  logic [31:0] ref_mem [logic [31:0]];
  exp_rsp_t    rsp_q [2][$];
  wb_m2s_t     iss_q [4][$];
  int          iss_age [4][$];
  int          left [2] = '{0, 0};
  logic        have_req [2] = '{1'b0, 1'b0};
  int          mode = 0;
  int          rate = 2;
  logic        age_check = 1'b0;
  int          cycle_cnt = 0;
  int          issued_cnt [2] = '{0, 0};
  int          ack_cnt [2] = '{0, 0};
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;

  wb_xbar_top dut0 (
    .clk_i (clk_i), .rst_i (rst_i),
    .m0_req_i (m_req[0]), .m1_req_i (m_req[1]),
    .m0_rsp_o (m_rsp[0]), .m1_rsp_o (m_rsp[1]),
    .s0_req_o (s_req[0]), .s1_req_o (s_req[1]),
    .s0_rsp_i (s_rsp[0]), .s1_rsp_i (s_rsp[1])
  );

  tb_slave_mem #(.SEED(32'd3041 + 32'd17)) u_slave0 (
    .clk_i (clk_i), .rst_i (rst_i), .req_i (s_req[0]), .rsp_o (s_rsp[0]),
    .hold_i (hold[0]), .heavy_i (heavy[0])
  );

  tb_slave_mem #(.SEED(32'd3041 + 32'd91)) u_slave1 (
    .clk_i (clk_i), .rst_i (rst_i), .req_i (s_req[1]), .rsp_o (s_rsp[1]),
    .hold_i (hold[1]), .heavy_i (heavy[1])
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // --------------------------------------------------------------------------
  // Scoreboard
  // --------------------------------------------------------------------------
  task automatic check_issue(input int s);
    wb_m2s_t r;
    wb_m2s_t e;
    int      m;
    int      idx;
    int      age;
    r = s_req[s];
    m = int'(r.addr[8]);
    idx = s * 2 + m;
    checks++;
    assert (iss_q[idx].size() != 0) else begin
      errors++;
      $display("slave %0d got a request that no master sent there, addr %h", s, r.addr);
    end
    if (iss_q[idx].size() != 0) begin
      e = iss_q[idx].pop_front();
      age = iss_age[idx].pop_front();
      assert (r.addr == e.addr && r.data == e.data && r.sel == e.sel && r.we == e.we)
      else begin
        errors++;
        $display("mismatch s%0d_req: got %h expected %h", s,
                 {r.addr, r.data, r.sel, r.we}, {e.addr, e.data, e.sel, e.we});
      end
      // The other master's oldest pending request must not be older
      if (age_check && iss_age[s * 2 + 1 - m].size() != 0) begin
        assert (iss_age[s * 2 + 1 - m][0] > age) else begin
          errors++;
          $display("slave %0d issued master %0d ahead of an older request", s, m);
        end
      end
    end
  endtask

  task automatic check_response(input int m);
    exp_rsp_t e;
    checks++;
    assert (rsp_q[m].size() != 0) else begin
      errors++;
      $display("master %0d got a response with nothing outstanding", m);
    end
    if (rsp_q[m].size() != 0) begin
      e = rsp_q[m].pop_front();
      assert (m_rsp[m].err == e.err) else begin
        errors++;
        $display("mismatch m%0d_rsp err: got %h expected %h", m, m_rsp[m].err, e.err);
      end
      if (e.rd && !e.err) begin
        assert (m_rsp[m].data == e.data) else begin
          errors++;
          $display("mismatch m%0d_rsp data: got %h expected %h", m, m_rsp[m].data, e.data);
        end
      end
    end
  endtask

  // Reference model update at acceptance
  task automatic record_accept(input int m);
    wb_m2s_t     r;
    exp_rsp_t    e;
    logic [31:0] cur;
    int          slv;
    r = m_req[m];
    e = '0;
    if ((r.addr & S0_MASK) == S0_BASE)
      slv = 0;
    else if ((r.addr & S1_MASK) == S1_BASE)
      slv = 1;
    else
      slv = -1;
    cur = ref_mem.exists(r.addr) ? ref_mem[r.addr] : 32'h0;
    if (slv < 0) begin
      e.err = 1'b1;
    end else begin
      if (r.we) begin
        for (int b = 0; b < 4; b++) begin
          if (r.sel[b])
            cur[8*b +: 8] = r.data[8*b +: 8];
        end
        ref_mem[r.addr] = cur;
      end else begin
        e.rd   = 1'b1;
        e.data = cur;
      end
      iss_q[slv * 2 + m].push_back(r);
      iss_age[slv * 2 + m].push_back(cycle_cnt * 2 + m);
      issued_cnt[m]++;
    end
    rsp_q[m].push_back(e);
    have_req[m] = 1'b0;
  endtask

  task automatic drive_next(input int m);
    logic [31:0] r;
    logic [31:0] base;
    if (!have_req[m] && left[m] > 0 && int'(lcg_next() >> 30) < rate) begin
      r = lcg_next();
      if (mode == 1)
        base = S0_BASE;
      else if (mode == 2)
        base = (m == 0) ? S0_BASE : S1_BASE;
      else if (r[27:25] == 3'd0)
        base = NO_SLAVE;
      else
        base = r[24] ? S1_BASE : S0_BASE;
      // Bit 8 keeps each master in its own part of every window
      m_req[m].addr = base | (32'(m) << 8) | (32'(r[30:28]) << 2);
      m_req[m].data = lcg_next();
      m_req[m].sel  = r[23:20];
      m_req[m].we   = r[19];
      m_req[m].cyc  = 1'b1;
      m_req[m].stb  = 1'b1;
      have_req[m] = 1'b1;
      left[m]--;
    end else if (!have_req[m]) begin
      m_req[m] = '0;
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_i) begin
      cycle_cnt++;
      for (int s = 0; s < 2; s++) begin
        if (s_req[s].cyc && s_req[s].stb && !s_rsp[s].stall)
          check_issue(s);
      end
      for (int m = 0; m < 2; m++) begin
        if (m_rsp[m].ack)
          ack_cnt[m]++;
        if (m_rsp[m].ack || m_rsp[m].err)
          check_response(m);
      end
      // Master 0 first, so same-cycle ties rank it older
      for (int m = 0; m < 2; m++) begin
        if (have_req[m] && !m_rsp[m].stall)
          record_accept(m);
      end
    end
    #2;
    for (int m = 0; m < 2; m++)
      drive_next(m);
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  task automatic check_idle();
    checks++;
    for (int i = 0; i < 2; i++) begin
      assert (!m_rsp[i].ack && !m_rsp[i].err && !m_rsp[i].stall) else begin
        errors++;
        $display("master %0d reply not idle around reset", i);
      end
      assert (!s_req[i].cyc && !s_req[i].stb) else begin
        errors++;
        $display("slave %0d bus not idle around reset", i);
      end
    end
  endtask

  function automatic logic all_idle();
    return left[0] == 0 && left[1] == 0 && !have_req[0] && !have_req[1] &&
           rsp_q[0].size() == 0 && rsp_q[1].size() == 0 &&
           iss_q[0].size() == 0 && iss_q[1].size() == 0 &&
           iss_q[2].size() == 0 && iss_q[3].size() == 0;
  endfunction

  task automatic run_traffic(input int md, input int rt, input int n0, input int n1);
    mode = md;
    rate = rt;
    left[0] = n0;
    left[1] = n1;
    @(posedge clk_i);
    while (!all_idle())
      @(posedge clk_i);
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    $display("test %-16s %s, %0d errors", name,
             (errors == err_before) ? "passed" : "FAILED", errors - err_before);
  endtask

  initial begin
    int err0;
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      @(posedge clk_i);
      #2;
      if (i >= 2)
        check_idle();
    end
    rst_i = 1'b0;
    @(posedge clk_i);
    #2;
    check_idle();
    report("reset", err0);

    err0 = errors;
    run_traffic(0, 2, 60, 60);
    report("mixed_traffic", err0);

    err0 = errors;
    heavy[0] = 1'b1;
    age_check = 1'b1;
    run_traffic(1, 4, 40, 40);
    heavy[0] = 1'b0;
    age_check = 1'b0;
    report("shared_slave_age", err0);

    err0 = errors;
    hold[0] = 1'b1;
    mode = 2;
    rate = 4;
    left[0] = 20;
    left[1] = 30;
    @(posedge clk_i);
    while (left[1] != 0 || have_req[1] || rsp_q[1].size() != 0)
      @(posedge clk_i);
    @(posedge clk_i);
    #1;
    checks++;
    assert (have_req[0] && m_rsp[0].stall) else begin
      errors++;
      $display("master 0 not stalled while slave 0 is held");
    end
    hold[0] = 1'b0;
    while (!all_idle())
      @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    for (int m = 0; m < 2; m++) begin
      checks++;
      assert (issued_cnt[m] == ack_cnt[m]) else begin
        errors++;
        $display("mismatch m%0d_rsp ack count: got %h expected %h", m, ack_cnt[m],
                 issued_cnt[m]);
      end
    end
    report("back_pressure", err0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Watchdog sized from the request count of all tests
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, traffic did not drain", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_xbar_models.sv
/*
  Wishbone pipelined slave memory model
  Byte-addressed word memory behind a pipelined slave interface.
  Raises stall at random (or on request) and acks each accepted
  request in order, zero to three cycles after the earliest ack slot.
*/
`default_nettype none

module tb_slave_mem
  import wb_xbar_pkg::*;
#(
  parameter logic [31:0] SEED = 32'd3041
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  wb_m2s_t req_i,
  output wb_s2m_t rsp_o,
  input  logic    hold_i,
  input  logic    heavy_i
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] lcg_state = SEED;
  logic [31:0] mem [logic [31:0]];
  logic [31:0] pend_data [$];
  int          pend_due [$];
  int          cycle_cnt = 0;
  wb_s2m_t     rsp_q = '0;

  assign rsp_o = rsp_q;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  always @(posedge clk_i) begin
    logic [31:0] r;
    logic [31:0] cur;
    wb_s2m_t     nxt;
    nxt = '0;
    if (rst_i) begin
      pend_data.delete();
      pend_due.delete();
    end else begin
      r = lcg_next();
      // Request taken on this edge
      if (req_i.cyc && req_i.stb && !rsp_q.stall) begin
        cur = mem.exists(req_i.addr) ? mem[req_i.addr] : 32'h0;
        if (req_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (req_i.sel[b])
              cur[8*b +: 8] = req_i.data[8*b +: 8];
          end
          mem[req_i.addr] = cur;
        end
        pend_data.push_back(cur);
        pend_due.push_back(cycle_cnt + int'(r[29:28]));
      end
      if (pend_due.size() != 0 && pend_due[0] <= cycle_cnt) begin
        nxt.ack  = 1'b1;
        nxt.data = pend_data.pop_front();
        void'(pend_due.pop_front());
      end
      if (heavy_i)
        nxt.stall = hold_i || (r[23:22] != 2'd0);
      else
        nxt.stall = hold_i || (r[23:22] == 2'd0);
      cycle_cnt++;
    end
    #2;
    rsp_q = nxt;
  end

endmodule

`default_nettype wire

//--- design/wb_xbar_top.sv
/*
  Wishbone pipelined crossbar, two masters by two slaves
  Holds the shared age-tag counter and wires both master ports and
  both slave ports through four request and four response FIFOs.
*/
`default_nettype none

module wb_xbar_top
  import wb_xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  wb_m2s_t   m0_req_i,
  input  wb_m2s_t   m1_req_i,
  output wb_m_rsp_t m0_rsp_o,
  output wb_m_rsp_t m1_rsp_o,
  output wb_m2s_t   s0_req_o,
  output wb_m2s_t   s1_req_o,
  input  wb_s2m_t   s0_rsp_i,
  input  wb_s2m_t   s1_rsp_i
);

  logic [TAG_W-1:0] tag_q;
  logic             m0_accept;
  logic             m1_accept;

  // Request paths, indexed [master][slave]
  logic      req_push  [2][2];
  logic      req_pop   [2][2];
  logic      req_full  [2][2];
  logic      req_empty [2][2];
  xbar_req_t req_in    [2];
  xbar_req_t req_head  [2][2];

  // Response paths, indexed [slave][master]
  logic      rsp_push  [2][2];
  logic      rsp_pop   [2][2];
  logic      rsp_full  [2][2];
  logic      rsp_empty [2][2];
  xbar_rsp_t rsp_in    [2];
  xbar_rsp_t rsp_head  [2][2];

  // --------------------------------------------------------------------------
  // Age tag, shared by both masters
  // --------------------------------------------------------------------------
  assign m0_accept = m0_req_i.cyc & m0_req_i.stb & ~m0_rsp_o.stall;
  assign m1_accept = m1_req_i.cyc & m1_req_i.stb & ~m1_rsp_o.stall;

  always_ff @(posedge clk_i) begin
    if (rst_i)
      tag_q <= '0;
    else if (m0_accept || m1_accept)
      tag_q <= tag_q + 1'b1;
  end

  // --------------------------------------------------------------------------
  // Path FIFOs
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < 2; i++) begin : g_row
    for (genvar j = 0; j < 2; j++) begin : g_col
      // Master i toward slave j
      xbar_fifo #(.payload_t(xbar_req_t), .DEPTH_AW(FIFO_AW)) u_req_fifo (
        .clk_i (clk_i), .rst_i (rst_i),
        .push_i (req_push[i][j]), .data_i (req_in[i]),
        .pop_i (req_pop[i][j]), .data_o (req_head[i][j]),
        .empty_o (req_empty[i][j]), .full_o (req_full[i][j])
      );
      // Slave i back to master j, guarded by the slave port credits
      xbar_fifo #(.payload_t(xbar_rsp_t), .DEPTH_AW(FIFO_AW)) u_rsp_fifo (
        .clk_i (clk_i), .rst_i (rst_i),
        .push_i (rsp_push[i][j]), .data_i (rsp_in[i]),
        .pop_i (rsp_pop[i][j]), .data_o (rsp_head[i][j]),
        .empty_o (rsp_empty[i][j]), .full_o (rsp_full[i][j])
      );
      a_rsp_room: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_push[i][j] |-> !rsp_full[i][j] || rsp_pop[i][j])
        else $error("response FIFO push with no credit");
    end
  end

  // --------------------------------------------------------------------------
  // Master ports
  // --------------------------------------------------------------------------
  xbar_master_port u_m0_port (
    .clk_i (clk_i), .rst_i (rst_i),
    .m_req_i (m0_req_i), .tag_i (tag_q), .m_rsp_o (m0_rsp_o),
    .s0_push_o (req_push[0][0]), .s1_push_o (req_push[0][1]), .req_o (req_in[0]),
    .s0_full_i (req_full[0][0]), .s1_full_i (req_full[0][1]),
    .s0_rsp_i (rsp_head[0][0]), .s1_rsp_i (rsp_head[1][0]),
    .s0_empty_i (rsp_empty[0][0]), .s1_empty_i (rsp_empty[1][0]),
    .s0_pop_o (rsp_pop[0][0]), .s1_pop_o (rsp_pop[1][0])
  );

  xbar_master_port u_m1_port (
    .clk_i (clk_i), .rst_i (rst_i),
    .m_req_i (m1_req_i), .tag_i (tag_q), .m_rsp_o (m1_rsp_o),
    .s0_push_o (req_push[1][0]), .s1_push_o (req_push[1][1]), .req_o (req_in[1]),
    .s0_full_i (req_full[1][0]), .s1_full_i (req_full[1][1]),
    .s0_rsp_i (rsp_head[0][1]), .s1_rsp_i (rsp_head[1][1]),
    .s0_empty_i (rsp_empty[0][1]), .s1_empty_i (rsp_empty[1][1]),
    .s0_pop_o (rsp_pop[0][1]), .s1_pop_o (rsp_pop[1][1])
  );

  // --------------------------------------------------------------------------
  // Slave ports
  // --------------------------------------------------------------------------
  xbar_slave_port u_s0_port (
    .clk_i (clk_i), .rst_i (rst_i),
    .m0_req_i (req_head[0][0]), .m1_req_i (req_head[1][0]),
    .m0_empty_i (req_empty[0][0]), .m1_empty_i (req_empty[1][0]),
    .m0_pop_o (req_pop[0][0]), .m1_pop_o (req_pop[1][0]),
    .s_req_o (s0_req_o), .s_rsp_i (s0_rsp_i),
    .m0_push_o (rsp_push[0][0]), .m1_push_o (rsp_push[0][1]), .rsp_o (rsp_in[0]),
    .m0_rsp_pop_i (rsp_pop[0][0]), .m1_rsp_pop_i (rsp_pop[0][1])
  );

  xbar_slave_port u_s1_port (
    .clk_i (clk_i), .rst_i (rst_i),
    .m0_req_i (req_head[0][1]), .m1_req_i (req_head[1][1]),
    .m0_empty_i (req_empty[0][1]), .m1_empty_i (req_empty[1][1]),
    .m0_pop_o (req_pop[0][1]), .m1_pop_o (req_pop[1][1]),
    .s_req_o (s1_req_o), .s_rsp_i (s1_rsp_i),
    .m0_push_o (rsp_push[1][0]), .m1_push_o (rsp_push[1][1]), .rsp_o (rsp_in[1]),
    .m0_rsp_pop_i (rsp_pop[1][0]), .m1_rsp_pop_i (rsp_pop[1][1])
  );

endmodule

`default_nettype wire

//--- design/xbar_slave_port.sv
/*
  Crossbar slave port
  Picks the older of the two queued request heads (master 0 on a tie),
  drives it onto the slave bus under Wishbone pipelined stall, and
  steers each ack into the response FIFO of the owning master. Credit
  counters keep every response FIFO from overflowing.
*/
`default_nettype none

module xbar_slave_port
  import wb_xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  // Request FIFO heads
  input  xbar_req_t m0_req_i,
  input  xbar_req_t m1_req_i,
  input  logic      m0_empty_i,
  input  logic      m1_empty_i,
  output logic      m0_pop_o,
  output logic      m1_pop_o,
  // Slave bus
  output wb_m2s_t   s_req_o,
  input  wb_s2m_t   s_rsp_i,
  // Response FIFOs toward the masters
  output logic      m0_push_o,
  output logic      m1_push_o,
  output xbar_rsp_t rsp_o,
  input  logic      m0_rsp_pop_i,
  input  logic      m1_rsp_pop_i
);

  logic [FIFO_AW:0] credit_q [2];
  logic [1:0]       take;
  logic [1:0]       give;
  logic             pick_m1;
  logic             cand_valid;
  logic             cand_credit;
  logic             load_ok;
  logic             issue;
  xbar_req_t        cand;
  xbar_req_t        req_q;
  logic             stb_q;
  logic             if_owner;
  logic             if_empty;
  logic             if_full;

  // --------------------------------------------------------------------------
  // Age arbitration
  // --------------------------------------------------------------------------
  always_comb begin
    if (m0_empty_i)
      pick_m1 = 1'b1;
    else if (m1_empty_i)
      pick_m1 = 1'b0;
    else
      pick_m1 = tag_older(m1_req_i.tag, m0_req_i.tag);
  end

  assign cand        = pick_m1 ? m1_req_i : m0_req_i;
  assign cand_valid  = !(m0_empty_i && m1_empty_i);
  assign cand_credit = pick_m1 ? (credit_q[1] != '0) : (credit_q[0] != '0);

  // Output register is free when empty or being taken this cycle
  assign load_ok = !stb_q || !s_rsp_i.stall;
  assign issue   = load_ok && cand_valid && cand_credit;

  assign m0_pop_o = issue && !pick_m1;
  assign m1_pop_o = issue && pick_m1;

  // --------------------------------------------------------------------------
  // Credits, one per free response FIFO entry
  // --------------------------------------------------------------------------
  assign take = {m1_pop_o, m0_pop_o};
  assign give = {m1_rsp_pop_i, m0_rsp_pop_i};

  always_ff @(posedge clk_i) begin
    for (int m = 0; m < 2; m++) begin
      if (rst_i)
        credit_q[m] <= {1'b1, {FIFO_AW{1'b0}}};
      else
        credit_q[m] <= credit_q[m] - take[m] + give[m];
    end
  end

  // --------------------------------------------------------------------------
  // Bus side
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i)
      stb_q <= 1'b0;
    else if (load_ok)
      stb_q <= issue;
  end

  always_ff @(posedge clk_i) begin
    if (issue)
      req_q <= cand;
  end

  // Owner of every issued request, oldest first; sized for all credits
  xbar_fifo #(
    .payload_t (logic),
    .DEPTH_AW  (FIFO_AW + 1)
  ) u_inflight_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (issue),
    .data_i  (pick_m1),
    .pop_i   (s_rsp_i.ack),
    .data_o  (if_owner),
    .empty_o (if_empty),
    .full_o  (if_full)
  );

  // Cycle held open until the last ack
  assign s_req_o = '{addr: req_q.addr, data: req_q.data, sel: req_q.sel,
                     cyc: !if_empty, stb: stb_q, we: req_q.we};

  assign m0_push_o = s_rsp_i.ack && !if_owner;
  assign m1_push_o = s_rsp_i.ack && if_owner;
  assign rsp_o     = '{data: s_rsp_i.data};

  a_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    s_req_o.stb |-> s_req_o.cyc)
    else $error("slave port stb without cyc");

  a_ack_inflight: assert property (@(posedge clk_i) disable iff (rst_i)
    s_rsp_i.ack |-> !if_empty)
    else $error("slave port ack with nothing in flight");

  // Credits bound the number of requests in flight
  a_credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    if_full |-> !issue)
    else $error("slave port issue beyond credits");

endmodule

`default_nettype wire

//--- design/xbar_master_port.sv
/*
  Crossbar master port
  Decodes each accepted request against the two slave windows, queues
  it toward the target slave with the current age tag, and releases
  ack or err back to the master strictly in request order.
*/
`default_nettype none

module xbar_master_port
  import wb_xbar_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  wb_m2s_t          m_req_i,
  input  logic [TAG_W-1:0] tag_i,
  output wb_m_rsp_t        m_rsp_o,
  // Request FIFOs toward the slaves
  output logic             s0_push_o,
  output logic             s1_push_o,
  output xbar_req_t        req_o,
  input  logic             s0_full_i,
  input  logic             s1_full_i,
  // Response FIFOs from the slaves
  input  xbar_rsp_t        s0_rsp_i,
  input  xbar_rsp_t        s1_rsp_i,
  input  logic             s0_empty_i,
  input  logic             s1_empty_i,
  output logic             s0_pop_o,
  output logic             s1_pop_o
);

  logic              hit0;
  logic              hit1;
  logic              stall;
  logic              accept;
  xbar_ord_t         ord_in;
  xbar_ord_t         ord_head;
  logic              ord_full;
  logic              ord_empty;
  logic              ord_pop;
  logic              ack_q;
  logic              err_q;
  logic [DATA_W-1:0] data_q;

  // --------------------------------------------------------------------------
  // Decode and accept
  // --------------------------------------------------------------------------
  assign hit0 = (m_req_i.addr & S0_MASK) == S0_BASE;
  assign hit1 = !hit0 && ((m_req_i.addr & S1_MASK) == S1_BASE);

  // Only this master's own queues hold it off
  assign stall  = ord_full | (hit0 & s0_full_i) | (hit1 & s1_full_i);
  assign accept = m_req_i.cyc & m_req_i.stb & ~stall;

  assign s0_push_o = accept & hit0;
  assign s1_push_o = accept & hit1;
  assign req_o     = '{addr: m_req_i.addr, data: m_req_i.data, sel: m_req_i.sel,
                       we: m_req_i.we, tag: tag_i};

  // Misses go only into the order FIFO
  assign ord_in.route = hit0 ? ROUTE_S0 : (hit1 ? ROUTE_S1 : ROUTE_ERR);

  // Room for a full request FIFO toward each slave
  xbar_fifo #(
    .payload_t (xbar_ord_t),
    .DEPTH_AW  (FIFO_AW + 1)
  ) u_ord_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (accept),
    .data_i  (ord_in),
    .pop_i   (ord_pop),
    .data_o  (ord_head),
    .empty_o (ord_empty),
    .full_o  (ord_full)
  );

  // --------------------------------------------------------------------------
  // In-order response release, one per cycle
  // --------------------------------------------------------------------------
  always_comb begin
    s0_pop_o = 1'b0;
    s1_pop_o = 1'b0;
    ord_pop  = 1'b0;
    if (!ord_empty) begin
      case (ord_head.route)
        ROUTE_S0: begin
          s0_pop_o = !s0_empty_i;
          ord_pop  = !s0_empty_i;
        end
        ROUTE_S1: begin
          s1_pop_o = !s1_empty_i;
          ord_pop  = !s1_empty_i;
        end
        // Unmapped entry answers at once
        default: ord_pop = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= s0_pop_o | s1_pop_o;
      err_q <= ord_pop & (ord_head.route == ROUTE_ERR);
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= s1_pop_o ? s1_rsp_i.data : s0_rsp_i.data;
  end

  assign m_rsp_o = '{data: data_q, stall: stall, ack: ack_q, err: err_q};

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(m_rsp_o.ack && m_rsp_o.err))
    else $error("master port ack and err together");

endmodule

`default_nettype wire

//--- design/xbar_fifo.sv
/*
  Path FIFO
  Register-array FIFO with a payload type parameter. The head entry
  is visible on data_o without a pop; full and empty are levels.
*/
`default_nettype none

module xbar_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH_AW  = 2
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  payload_t          mem [2**DEPTH_AW];
  // Extra pointer bit tells full from empty
  logic [DEPTH_AW:0] wr_ptr;
  logic [DEPTH_AW:0] rd_ptr;
  logic              do_push;
  logic              do_pop;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[DEPTH_AW] != rd_ptr[DEPTH_AW]) &&
                   (wr_ptr[DEPTH_AW-1:0] == rd_ptr[DEPTH_AW-1:0]);

  // A push into a full FIFO is fine when the head leaves the same cycle
  assign do_push = push_i && (!full_o || pop_i);
  assign do_pop  = pop_i && !empty_o;

  assign data_o = mem[rd_ptr[DEPTH_AW-1:0]];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push)
      mem[wr_ptr[DEPTH_AW-1:0]] <= data_i;
  end

  // Callers must respect the levels
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i && full_o |-> pop_i)
    else $error("xbar_fifo push while full");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    !(pop_i && empty_o))
    else $error("xbar_fifo pop while empty");

endmodule

`default_nettype wire

//--- design/wb_xbar_pkg.sv
/*
  Wishbone crossbar shared definitions
  Bus widths, slave address windows, age-tag width, path FIFO
  payloads and the wrap-around age comparison used by the arbiters.
*/
`default_nettype none

package wb_xbar_pkg;

  // --------------------------------------------------------------------------
  // Widths and address map
  // --------------------------------------------------------------------------
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int SEL_W   = DATA_W / 8;
  localparam int FIFO_AW = 2;
  // Two spare bits keep the modulo compare valid with every FIFO full
  localparam int TAG_W   = FIFO_AW + 2;

  localparam logic [ADDR_W-1:0] S0_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] S0_MASK = 32'hF000_0000;
  localparam logic [ADDR_W-1:0] S1_BASE = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] S1_MASK = 32'hF000_0000;

  // Route codes kept in the master order FIFO
  localparam logic [1:0] ROUTE_S0  = 2'd0;
  localparam logic [1:0] ROUTE_S1  = 2'd1;
  localparam logic [1:0] ROUTE_ERR = 2'd2;

  // --------------------------------------------------------------------------
  // Path FIFO payloads
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [SEL_W-1:0]  sel;
    logic              we;
    logic [TAG_W-1:0]  tag;
  } xbar_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
  } xbar_rsp_t;

  typedef struct packed {
    logic [1:0] route;
  } xbar_ord_t;

  // --------------------------------------------------------------------------
  // Wishbone pipelined bus bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [SEL_W-1:0]  sel;
    logic              cyc;
    logic              stb;
    logic              we;
  } wb_m2s_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              stall;
    logic              ack;
  } wb_s2m_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              stall;
    logic              ack;
    logic              err;
  } wb_m_rsp_t;

  // True when tag a was stamped strictly before tag b, modulo 2^TAG_W
  function automatic logic tag_older(input logic [TAG_W-1:0] a,
                                     input logic [TAG_W-1:0] b);
    logic [TAG_W-1:0] diff;
    diff = b - a;
    return (diff != '0) && !diff[TAG_W-1];
  endfunction

endpackage

`default_nettype wire
